// File: alu.sv
`include "rv_params.svh"

module alu import rv_pkg::*; (
    input  ctrl_t             ctrl,
    input  logic [`XLEN-1:0]  rs1_data,
    input  logic [`XLEN-1:0]  rs2_data,
    input  logic [`XLEN-1:0]  pc,
    input  logic [`XLEN-1:0]  imm,
    output logic [`XLEN-1:0]  result
);

    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;
    logic [4:0]       shamt;

    always_comb begin
        case (ctrl.alu_sel_rs1)
            `SRC1_PC:   op1 = pc;
            `SRC1_ZERO: op1 = '0;
            default:    op1 = rs1_data;
        endcase
    end

    assign op2   = (ctrl.alu_sel_rs2 == `SRC2_IMM) ? imm : rs2_data;
    assign shamt = op2[4:0];

    always_comb begin
        case (ctrl.alu_ctrl)
            `ALU_ADD:  result = op1 + op2;
            `ALU_SUB:  result = op1 - op2;
            `ALU_SLL:  result = op1 << shamt;
            `ALU_SLT:  result = {31'b0, $signed(op1) < $signed(op2)};
            `ALU_SLTU: result = {31'b0, op1 < op2};
            `ALU_XOR:  result = op1 ^ op2;
            `ALU_SRL:  result = op1 >> shamt;
            `ALU_SRA:  result = $unsigned($signed(op1) >>> shamt);
            `ALU_OR:   result = op1 | op2;
            `ALU_AND:  result = op1 & op2;
            default:   result = '0;
        endcase
    end

endmodule

// File: branch_unit.sv
`include "rv_params.svh"

module branch_unit import rv_pkg::*; (
    input  ctrl_t             ctrl,
    input  logic [2:0]        funct3,
    input  logic [`XLEN-1:0]  rs1_data,
    input  logic [`XLEN-1:0]  rs2_data,
    input  logic [`XLEN-1:0]  pc,
    input  logic [`XLEN-1:0]  alu_result,
    input  logic [`XLEN-1:0]  imm,
    output logic [`XLEN-1:0]  next_pc
);

    logic             taken;
    logic [`XLEN-1:0] pc_plus4;
    logic [`XLEN-1:0] jalr_target;

    assign pc_plus4    = pc + `XLEN'(4);
    assign jalr_target = (rs1_data + imm) & ~`XLEN'(1); // lsb cleared per spec

    always_comb begin
        case (funct3)
            3'b000:  taken = (rs1_data == rs2_data);
            3'b001:  taken = (rs1_data != rs2_data);
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  taken = (rs1_data < rs2_data);
            3'b111:  taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        next_pc = pc_plus4;
        if (ctrl.uncond_jump) begin
            next_pc = ctrl.pc_jal_sel ? jalr_target : alu_result;
        end else if (ctrl.meet_branch && taken) begin
            next_pc = alu_result; // alu adds pc and b immediate
        end
    end

endmodule

// File: control_unit.sv
`include "rv_params.svh"

module control_unit import rv_pkg::*; (
    input  instr_u     instr,
    input  logic [2:0] op_type,
    output ctrl_t      ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt_op; // funct7 bit 5, picks sub or sra

    assign opcode = instr.r.opcode;
    assign funct3 = instr.r.funct3;
    // op-imm carries the shift qualifier in the top immediate bits
    assign alt_op = instr.i.imm_hi[5];

    always_comb begin
        ctrl = '0;

        ctrl.reg_write = 1'b1;
        if (opcode == `BRANCH || opcode == `STORE || op_type == `X_type) begin
            ctrl.reg_write = 1'b0;
        end

        ctrl.mem_write   = (opcode == `STORE);
        ctrl.uncond_jump = (opcode == `JAL) || (opcode == `JALR);
        ctrl.pc_jal_sel  = (opcode == `JALR);
        ctrl.meet_branch = (opcode == `BRANCH);
        ctrl.illegal     = (op_type == `X_type);

        ctrl.alu_ctrl = `ALU_ADD; // address and target math
        if (opcode == `CAL_R || opcode == `CAL_I) begin
            case (funct3)
                3'b000: begin
                    if (opcode == `CAL_R && alt_op) begin
                        ctrl.alu_ctrl = `ALU_SUB;
                    end else begin
                        ctrl.alu_ctrl = `ALU_ADD; // addi never subtracts
                    end
                end
                3'b001: ctrl.alu_ctrl = `ALU_SLL;
                3'b010: ctrl.alu_ctrl = `ALU_SLT;
                3'b011: ctrl.alu_ctrl = `ALU_SLTU;
                3'b100: ctrl.alu_ctrl = `ALU_XOR;
                3'b101: begin
                    if (alt_op) begin
                        ctrl.alu_ctrl = `ALU_SRA;
                    end else begin
                        ctrl.alu_ctrl = `ALU_SRL;
                    end
                end
                3'b110: ctrl.alu_ctrl = `ALU_OR;
                default: ctrl.alu_ctrl = `ALU_AND;
            endcase
        end

        ctrl.alu_sel_rs1 = `SRC1_REG;
        if (opcode == `AUIPC || opcode == `JAL || opcode == `BRANCH) begin
            ctrl.alu_sel_rs1 = `SRC1_PC; // pc-relative targets
        end else if (opcode == `LUI) begin
            ctrl.alu_sel_rs1 = `SRC1_ZERO;
        end

        ctrl.alu_sel_rs2 = (opcode == `CAL_R) ? `SRC2_REG : `SRC2_IMM;

        ctrl.result_sel = `RES_ALU;
        if (opcode == `LOAD) begin
            ctrl.result_sel = `RES_MEM;
        end else if (opcode == `JAL || opcode == `JALR) begin
            ctrl.result_sel = `RES_LINK;
        end
    end

endmodule

// File: imm_gen.sv
`include "rv_params.svh"

module imm_gen import rv_pkg::*; (
    input  instr_u            instr,
    input  logic [2:0]        op_type,
    output logic [`XLEN-1:0]  imm
);

    logic sign; // instruction bit 31

    assign sign = instr.r.funct7[6];

    always_comb begin
        case (op_type)
            `I_type: imm = {{20{sign}}, instr.i.imm_hi, instr.i.rs2_or_imm_lo};
            `S_type: imm = {{20{sign}}, instr.i.imm_hi, instr.i.imm_lo_or_rd};
            `B_type: imm = {{19{sign}}, sign, instr.i.imm_lo_or_rd[0],
                            instr.i.imm_hi[5:0], instr.i.imm_lo_or_rd[4:1], 1'b0};
            `U_type: imm = {instr.r.funct7, instr.r.rs2, instr.r.rs1,
                            instr.r.funct3, 12'b0};
            // j layout scatters imm[19:12] over rs1 and funct3
            `J_type: imm = {{11{sign}}, sign, instr.r.rs1, instr.r.funct3,
                            instr.r.rs2[0], instr.r.funct7[5:0], instr.r.rs2[4:1], 1'b0};
            default: imm = '0; // r and illegal carry no immediate
        endcase
    end

endmodule

// File: op_classifier.sv
`include "rv_params.svh"

module op_classifier (
    input  logic [6:0] opcode,
    output logic [2:0] op_type
);

    always_comb begin
        case (opcode)
            `CAL_R: op_type = `R_type;
            `CAL_I,
            `LOAD,
            `JALR: op_type = `I_type;
            `STORE: op_type = `S_type;
            `BRANCH: op_type = `B_type;
            `LUI,
            `AUIPC: op_type = `U_type;
            `JAL: op_type = `J_type;
            default: op_type = `X_type; // system, fence, anything unknown
        endcase
    end

endmodule

// File: reg_file.sv
`include "rv_params.svh"

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [4:0]        rs1_addr,
    input  logic [4:0]        rs2_addr,
    output logic [`XLEN-1:0]  rs1_data,
    output logic [`XLEN-1:0]  rs2_data,
    input  logic              we,
    input  logic [4:0]        rd_addr,
    input  logic [`XLEN-1:0]  rd_data
);

    logic [`XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data; // x0 stays zero
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and search the log for the pass line

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module rv_exec_core_tb -f rv_exec_core.f \
    && ./obj_dir/Vrv_exec_core_tb > sim.log 2>&1

grep -qx '>>> PASS' sim.log || { echo "simulation failed, see sim.log"; exit 1; }
echo "simulation passed"

// File: rv_exec_core.f
+incdir+.
rv_pkg.sv
op_classifier.sv
control_unit.sv
imm_gen.sv
alu.sv
branch_unit.sv
reg_file.sv
rv_exec_core.sv
rv_exec_core_chk.sv
rv_exec_core_tb.sv

// File: rv_exec_core.sv
`include "rv_params.svh"

module rv_exec_core import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req,
    output logic      ack,
    input  exec_req_t req_data,
    output exec_rsp_t rsp
);

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        RESP
    } state_t;

    state_t           state;
    exec_req_t        req_q;    // held for the whole transaction
    exec_rsp_t        rsp_q;
    exec_rsp_t        rsp_next;
    logic             ack_q;

    logic [2:0]       op_type;
    ctrl_t            ctrl;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] next_pc;
    logic [`XLEN-1:0] link_addr;
    logic [`XLEN-1:0] wb_data;
    logic             rf_we;

    op_classifier u_classifier (
        .opcode  (req_q.instr.r.opcode),
        .op_type (op_type)
    );

    control_unit u_control (
        .instr   (req_q.instr),
        .op_type (op_type),
        .ctrl    (ctrl)
    );

    imm_gen u_imm (
        .instr   (req_q.instr),
        .op_type (op_type),
        .imm     (imm)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (req_q.instr.r.rs1),
        .rs2_addr (req_q.instr.r.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rf_we),
        .rd_addr  (req_q.instr.r.rd),
        .rd_data  (wb_data)
    );

    alu u_alu (
        .ctrl     (ctrl),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .pc       (req_q.pc),
        .imm      (imm),
        .result   (alu_result)
    );

    // b layout shares the i/s field positions
    branch_unit u_branch (
        .ctrl       (ctrl),
        .funct3     (req_q.instr.i.funct3),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .pc         (req_q.pc),
        .alu_result (alu_result),
        .imm        (imm),
        .next_pc    (next_pc)
    );

    assign link_addr = req_q.pc + `XLEN'(4);

    always_comb begin
        case (ctrl.result_sel)
            `RES_MEM:  wb_data = req_q.load_data;
            `RES_LINK: wb_data = link_addr;
            default:   wb_data = alu_result;
        endcase
    end

    assign rf_we = (state == EXEC) && ctrl.reg_write; // one write per transaction

    always_comb begin
        rsp_next.rd_write    = ctrl.reg_write;
        rsp_next.rd_addr     = req_q.instr.r.rd;
        rsp_next.rd_data     = wb_data;
        rsp_next.next_pc     = next_pc;
        rsp_next.store_valid = ctrl.mem_write;
        rsp_next.store_addr  = ctrl.mem_write ? alu_result : '0;
        rsp_next.store_data  = ctrl.mem_write ? rs2_data : '0;
        rsp_next.illegal     = ctrl.illegal;
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            req_q <= req_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            ack_q <= 1'b0;
            rsp_q <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    rsp_q <= rsp_next;
                    ack_q <= 1'b1; // seen high two edges after req
                    state <= RESP;
                end
                RESP: begin
                    if (!req) begin // requester has taken the response
                        ack_q <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign ack = ack_q;
    assign rsp = rsp_q;

endmodule

// File: rv_exec_core_chk.sv
module rv_exec_core_chk import rv_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input logic      req,
    input logic      ack,
    input exec_rsp_t rsp
);

    ack_two_edges: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(req) |=> !ack ##1 ack)
        else $error("ack did not rise two edges after req");

    ack_held: assert property (@(posedge clk) disable iff (!rst_n)
        ack && req |=> ack)
        else $error("ack dropped while req was still high");

    rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ack |=> $stable(rsp))
        else $error("response changed while ack was high");

    ack_release: assert property (@(posedge clk) disable iff (!rst_n)
        ack && !req |=> !ack)
        else $error("ack did not fall one edge after req dropped");

    ack_in_reset: assert property (@(posedge clk)
        !rst_n |=> !ack)
        else $error("ack high after reset");

endmodule

bind rv_exec_core rv_exec_core_chk u_chk (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .ack   (ack),
    .rsp   (rsp)
);

// File: rv_exec_core_tb.sv
`include "rv_params.svh"

module rv_exec_core_tb import rv_pkg::*; ();

    localparam int RESET_CYCLES = 10;
    localparam int NUM_INSTR    = 24 + 6 + 18 + 3 + 3 + 5; // per test, in run order
    localparam int MAX_CYCLES   = NUM_INSTR * 8 + RESET_CYCLES;

    logic        clk;
    logic        rst_n;
    logic        req;
    logic        ack;
    exec_req_t   req_data;
    exec_rsp_t   rsp;
    exec_rsp_t   got;       // response sampled while ack is high
    logic [31:0] shadow [32];
    logic [31:0] rng_state;
    logic [31:0] pc_cur;
    logic [31:0] cur_instr;
    int          cycles = 0;
    int          n_pass;
    int          n_fail;

    rv_exec_core DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .ack      (ack),
        .req_data (req_data),
        .rsp      (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // rv32i encodings
    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `CAL_R};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `STORE};
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `BRANCH};
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `JAL};
    endfunction

    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $unsigned($signed(a) >>> b[4:0]);
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
            input logic [31:0] b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic compare_word(input string what, input logic [31:0] actual,
            input logic [31:0] expected);
        assert (actual === expected) n_pass++;
        else begin
            $display("Mismatch at %0t: %s is %h, expected %h (instr %h)",
                     $time, what, actual, expected, cur_instr);
            n_fail++;
        end
    endtask

    // one four-phase handshake
    task automatic transact(input logic [31:0] instr, input logic [31:0] ld);
        cur_instr = instr;
        @(posedge clk);
        req      <= 1'b1;
        req_data <= {instr, pc_cur, ld};
        do @(posedge clk); while (!ack);
        got = rsp;
        req <= 1'b0;
        do @(posedge clk); while (ack);
    endtask

    task automatic step(input logic [31:0] instr, input logic [31:0] ld, input logic wr,
            input logic [31:0] data, input logic [31:0] npc, input logic st,
            input logic [31:0] saddr, input logic [31:0] sdata, input logic ill);
        transact(instr, ld);
        compare_word("rd_write", {31'd0, got.rd_write}, {31'd0, wr});
        compare_word("next_pc", got.next_pc, npc);
        compare_word("store_valid", {31'd0, got.store_valid}, {31'd0, st});
        compare_word("illegal", {31'd0, got.illegal}, {31'd0, ill});
        if (wr) begin
            compare_word("rd_addr", {27'd0, got.rd_addr}, {27'd0, instr[11:7]});
            compare_word("rd_data", got.rd_data, data);
            if (instr[11:7] != 5'd0) begin
                shadow[instr[11:7]] = data; // x0 never changes
            end
        end
        if (st) begin
            compare_word("store_addr", got.store_addr, saddr);
            compare_word("store_data", got.store_data, sdata);
        end
        pc_cur = npc;
    endtask

    task automatic alu_instr(input logic [31:0] instr, input logic [31:0] expected);
        step(instr, 32'd0, 1'b1, expected, pc_cur + 32'd4, 1'b0, 32'd0, 32'd0, 1'b0);
    endtask

    task automatic load_reg(input logic [4:0] rd, input logic [31:0] val);
        logic [31:0] lo;
        logic [31:0] hi;
        lo = {{20{val[11]}}, val[11:0]};
        hi = val - lo; // addi sign-extends, so round the upper part
        alu_instr({hi[31:12], rd, `LUI}, hi);
        alu_instr(i_word(val[11:0], rd, 3'b000, rd, `CAL_I), val);
    endtask

    task automatic report_test(input string name, input int fails_before);
        if (n_fail == fails_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d check(s) failed", name, n_fail - fails_before);
        end
    endtask

    task automatic register_alu_ops();
        logic [3:0] ops [10];   // {funct7 bit 5, funct3}
        logic [4:0] rs1;
        logic [4:0] rs2;
        int         fails_before;
        fails_before = n_fail;
        ops = '{4'b0000, 4'b1000, 4'b0001, 4'b0010, 4'b0011,
                4'b0100, 4'b0101, 4'b1101, 4'b0110, 4'b0111};
        load_reg(5'd1, xorshift32() | 32'h8000_0000); // negative
        load_reg(5'd2, xorshift32() & 32'h7fff_ffff); // positive
        for (int swap = 0; swap < 2; swap++) begin
            rs1 = (swap == 0) ? 5'd1 : 5'd2;
            rs2 = (swap == 0) ? 5'd2 : 5'd1;
            for (int k = 0; k < 10; k++) begin
                alu_instr(r_word({1'b0, ops[k][3], 5'd0}, rs2, rs1, ops[k][2:0], 5'(3 + k)),
                          ref_alu(ops[k][2:0], ops[k][3], shadow[rs1], shadow[rs2]));
            end
        end
        report_test("register alu ops", fails_before);
    endtask

    task automatic immediate_forms();
        logic [31:0] a;
        int          fails_before;
        fails_before = n_fail;
        a = shadow[1];
        alu_instr(i_word(12'hff9, 5'd1, 3'b000, 5'd13, `CAL_I), a + 32'hffff_fff9);
        alu_instr(i_word(12'h007, 5'd1, 3'b001, 5'd14, `CAL_I), a << 7);
        alu_instr(i_word(12'h009, 5'd1, 3'b101, 5'd15, `CAL_I), a >> 9);
        alu_instr(i_word(12'h409, 5'd1, 3'b101, 5'd16, `CAL_I), $unsigned($signed(a) >>> 9));
        alu_instr({20'habcde, 5'd17, `LUI}, 32'habcd_e000);
        alu_instr({20'h12345, 5'd18, `AUIPC}, pc_cur + 32'h1234_5000);
        report_test("immediate forms", fails_before);
    endtask

    task automatic branch_conditions();
        logic [2:0]  conds [6];
        logic [4:0]  src1 [3];
        logic [4:0]  src2 [3];
        logic [31:0] r;
        logic [31:0] off;
        logic [31:0] npc;
        int          fails_before;
        fails_before = n_fail;
        conds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        src1  = '{5'd1, 5'd2, 5'd1}; // neg/pos, pos/neg, equal
        src2  = '{5'd2, 5'd1, 5'd1};
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 3; p++) begin
                r   = xorshift32();
                off = {{19{r[12]}}, r[12:1], 1'b0};
                npc = branch_taken(conds[c], shadow[src1[p]], shadow[src2[p]]) ?
                      pc_cur + off : pc_cur + 32'd4;
                step(b_word(off[12:0], src2[p], src1[p], conds[c]), 32'd0, 1'b0, 32'd0, npc,
                     1'b0, 32'd0, 32'd0, 1'b0);
            end
        end
        report_test("branch conditions", fails_before);
    endtask

    task automatic jump_links();
        logic [31:0] r;
        logic [31:0] off;
        int          fails_before;
        fails_before = n_fail;
        r   = xorshift32();
        off = {{11{r[20]}}, r[20:1], 1'b0};
        step(j_word(off[20:0], 5'd20), 32'd0, 1'b1, pc_cur + 32'd4, pc_cur + off,
             1'b0, 32'd0, 32'd0, 1'b0);
        step(i_word(12'hffd, 5'd2, 3'b000, 5'd21, `JALR), 32'd0, 1'b1, pc_cur + 32'd4,
             (shadow[2] + 32'hffff_fffd) & ~32'd1, 1'b0, 32'd0, 32'd0, 1'b0);
        step(i_word(12'h155, 5'd1, 3'b000, 5'd22, `JALR), 32'd0, 1'b1, pc_cur + 32'd4,
             (shadow[1] + 32'h0000_0155) & ~32'd1, 1'b0, 32'd0, 32'd0, 1'b0);
        report_test("jumps", fails_before);
    endtask

    task automatic load_store();
        logic [31:0] ld;
        int          fails_before;
        fails_before = n_fail;
        ld = xorshift32();
        step(i_word(12'h008, 5'd1, 3'b010, 5'd23, `LOAD), ld, 1'b1, ld, pc_cur + 32'd4,
             1'b0, 32'd0, 32'd0, 1'b0);
        step(s_word(12'hff4, 5'd2, 5'd1), 32'd0, 1'b0, 32'd0, pc_cur + 32'd4,
             1'b1, shadow[1] + 32'hffff_fff4, shadow[2], 1'b0);
        step(s_word(12'h7f4, 5'd23, 5'd2), 32'd0, 1'b0, 32'd0, pc_cur + 32'd4,
             1'b1, shadow[2] + 32'h0000_07f4, shadow[23], 1'b0);
        report_test("loads and stores", fails_before);
    endtask

    task automatic zero_reg_and_illegal();
        int fails_before;
        fails_before = n_fail;
        alu_instr(i_word(12'h005, 5'd2, 3'b000, 5'd0, `CAL_I), shadow[2] + 32'd5);
        alu_instr(r_word(7'd0, 5'd0, 5'd0, 3'b000, 5'd24), 32'd0);
        alu_instr(r_word(7'd0, 5'd2, 5'd0, 3'b000, 5'd25), shadow[2]);
        step(32'h0000_0073, 32'd0, 1'b0, 32'd0, pc_cur + 32'd4, 1'b0, 32'd0, 32'd0, 1'b1);
        step(32'h0000_000f, 32'd0, 1'b0, 32'd0, pc_cur + 32'd4, 1'b0, 32'd0, 32'd0, 1'b1);
        report_test("x0 and illegal", fails_before);
    endtask

    initial begin
        rst_n     = 1'b0;
        req       = 1'b0;
        req_data  = '0;
        rng_state = 32'h35153a46;
        pc_cur    = 32'h0000_1000;
        n_pass    = 0;
        n_fail    = 0;
        foreach (shadow[i]) begin
            shadow[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        compare_word("ack after reset", {31'd0, ack}, 32'd0);
        register_alu_ops();
        immediate_forms();
        branch_conditions();
        jump_links();
        load_store();
        zero_reg_and_illegal();
        $display("checks passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

`define XLEN 32

`define LUI    7'b0110111
`define AUIPC  7'b0010111
`define JAL    7'b1101111
`define JALR   7'b1100111
`define BRANCH 7'b1100011
`define LOAD   7'b0000011
`define STORE  7'b0100011
`define CAL_I  7'b0010011 // op-imm
`define CAL_R  7'b0110011 // register op

`define R_type 3'd0
`define I_type 3'd1 // op-imm, load, jalr
`define S_type 3'd2
`define B_type 3'd3
`define U_type 3'd4
`define J_type 3'd5
`define X_type 3'd6 // system, fence, reserved

`define ALU_ADD  4'b0000
`define ALU_SUB  4'b0001
`define ALU_SLL  4'b0010
`define ALU_SLT  4'b0011
`define ALU_SLTU 4'b0100
`define ALU_XOR  4'b0101
`define ALU_SRL  4'b0110
`define ALU_SRA  4'b0111
`define ALU_OR   4'b1000
`define ALU_AND  4'b1001

`define SRC1_REG  2'd0
`define SRC1_PC   2'd1
`define SRC1_ZERO 2'd2 // lui
`define SRC2_REG  2'd0
`define SRC2_IMM  2'd1
`define RES_ALU   2'd0
`define RES_MEM   2'd1
`define RES_LINK  2'd2 // pc + 4 for jumps

`endif

// File: rv_pkg.sv
`include "rv_params.svh"

package rv_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [6:0] imm_hi;        // imm[11:5] for i and s
        logic [4:0] rs2_or_imm_lo; // i-type imm[4:0], s-type rs2
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo_or_rd;  // s-type imm[4:0], i-type rd
        logic [6:0] opcode;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef struct packed {
        logic       reg_write;
        logic [1:0] result_sel;
        logic       mem_write;
        logic       uncond_jump;
        logic       meet_branch;
        logic [3:0] alu_ctrl;
        logic [1:0] alu_sel_rs1;
        logic [1:0] alu_sel_rs2;
        logic       pc_jal_sel;  // jalr takes rs1 as base
        logic       illegal;
    } ctrl_t;

    typedef struct packed {
        instr_u            instr;
        logic [`XLEN-1:0]  pc;
        logic [`XLEN-1:0]  load_data; // only meaningful for loads
    } exec_req_t;

    typedef struct packed {
        logic              rd_write;
        logic [4:0]        rd_addr;
        logic [`XLEN-1:0]  rd_data;
        logic [`XLEN-1:0]  next_pc;
        logic              store_valid;
        logic [`XLEN-1:0]  store_addr;
        logic [`XLEN-1:0]  store_data;
        logic              illegal;
    } exec_rsp_t;

endpackage
